/* Makefile */
TOP := rvv_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f
	verilator --lint-only --top-module rvv_core_top hw/rvv_isa_pkg.sv hw/rvv_elem_pkg.sv \
		hw/vec_unit_if.sv hw/insn_dispatch.sv hw/valu_pipe.sv hw/vmem_unit.sv \
		hw/vreg_file.sv hw/rvv_core_top.sv

clean:
	rm -rf obj_dir

/* hw/insn_dispatch.sv */
`timescale 1ns/1ns

module insn_dispatch #(
    parameter int VLEN           = 64,
    parameter int NUM_VREG       = 32,
    parameter int MEM_ADDR_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rvv_isa_pkg::insn_t          insn,
    input  logic [MEM_ADDR_WIDTH-1:0]   scalar_op,
    input  logic                        insn_req,
    output logic                        insn_ack,
    alu_issue_if.src                    alu,
    mem_issue_if.src                    mem,
    output logic [$clog2(NUM_VREG)-1:0] rd_addr_a,
    output logic [$clog2(NUM_VREG)-1:0] rd_addr_b,
    input  logic [VLEN-1:0]             rd_data_a,
    input  logic [VLEN-1:0]             rd_data_b,
    output logic                        claim,
    output logic [$clog2(NUM_VREG)-1:0] claim_addr,
    input  logic [NUM_VREG-1:0]         busy
);
    localparam int RA_W = $clog2(NUM_VREG);

    logic [RA_W-1:0]                vs1;
    logic [RA_W-1:0]                vs2;
    logic [RA_W-1:0]                vd;
    logic                           is_op;
    logic                           is_cfg;
    logic                           is_alu;
    logic                           is_load;
    logic                           is_store;
    logic                           is_mem;
    logic                           f6_ok;
    logic                           mem_ok;
    logic                           stall;
    logic                           go;
    logic [rvv_elem_pkg::sew_w-1:0] sew_q;

    assign vs1 = insn.arith.vs1[RA_W-1:0];
    assign vs2 = insn.arith.vs2[RA_W-1:0];
    // vd and vs3 sit in the same bits in both views
    assign vd  = insn.arith.vd[RA_W-1:0];

    assign is_op  = insn.arith.opcode == rvv_isa_pkg::opc_op_v;
    // vsetvli has bit 31 clear, vsew 4 and up is reserved
    assign is_cfg = is_op && insn.arith.funct3 == rvv_isa_pkg::f3_cfg && !insn.bits[31]
                    && !insn.bits[rvv_isa_pkg::vsew_lsb + 2];

    always_comb begin
        case (insn.arith.funct6)
            rvv_isa_pkg::f6_add, rvv_isa_pkg::f6_sub, rvv_isa_pkg::f6_and,
            rvv_isa_pkg::f6_or, rvv_isa_pkg::f6_xor: f6_ok = 1'b1;
            default: f6_ok = 1'b0;
        endcase
    end

    assign is_alu = is_op && f6_ok && (insn.arith.funct3 == rvv_isa_pkg::f3_ivv
                                       || insn.arith.funct3 == rvv_isa_pkg::f3_ivi);

    // unit stride only; width 1..4 belongs to scalar fp
    assign mem_ok = (insn.mem.width == 3'd0 || (insn.mem.width[2] && insn.mem.width[1:0] != 2'd0))
                    && insn.mem.mop == 2'd0 && !insn.mem.mew && insn.mem.nf == 3'd0;
    assign is_load  = mem_ok && insn.mem.opcode == rvv_isa_pkg::opc_load;
    assign is_store = mem_ok && insn.mem.opcode == rvv_isa_pkg::opc_store;
    assign is_mem   = is_load || is_store;

    // port a also fetches store data
    assign rd_addr_a = is_store ? vd : vs1;
    assign rd_addr_b = vs2;

    // raw on sources, waw on vd, one memory op at a time
    always_comb begin
        stall = 1'b0;
        if (is_alu)
            stall = busy[vs2] || busy[vd]
                    || (insn.arith.funct3 == rvv_isa_pkg::f3_ivv && busy[vs1]);
        else if (is_mem)
            stall = busy[vd] || mem.req || mem.ack;
    end

    assign go = insn_req && !insn_ack && !stall;

    // stores write no register
    assign claim      = go && (is_alu || is_load);
    assign claim_addr = vd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            insn_ack  <= 1'b0;
            sew_q     <= rvv_elem_pkg::sew_e8;
            alu.valid <= 1'b0;
            mem.req   <= 1'b0;
        end else begin
            alu.valid <= go && is_alu;
            if (go)
                insn_ack <= 1'b1;
            else if (!insn_req)
                insn_ack <= 1'b0;
            if (go && is_cfg)
                sew_q <= insn.bits[rvv_isa_pkg::vsew_lsb +: rvv_elem_pkg::sew_w];
            // hold req until the unit has latched
            if (go && is_mem)
                mem.req <= 1'b1;
            else if (mem.ack)
                mem.req <= 1'b0;
        end
    end

    // issue payload
    always_ff @(posedge clk) begin
        if (go && is_alu) begin
            alu.funct6 <= insn.arith.funct6;
            alu.is_imm <= insn.arith.funct3 == rvv_isa_pkg::f3_ivi;
            alu.sew    <= sew_q;
            alu.vd     <= vd;
            alu.opnd_a <= rd_data_a;
            alu.opnd_b <= rd_data_b;
            alu.imm    <= insn.arith.vs1;
        end
        if (go && is_mem) begin
            mem.is_store <= is_store;
            mem.vd       <= vd;
            mem.addr     <= scalar_op;
            mem.wdata    <= rd_data_a;
        end
    end

endmodule

/* hw/rvv_core_top.sv */
`timescale 1ns/1ns

module rvv_core_top #(
    parameter int VLEN           = 64,
    parameter int NUM_VREG       = 32,
    parameter int MEM_ADDR_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // instruction handshake
    input  logic [31:0]               insn,
    input  logic [MEM_ADDR_WIDTH-1:0] scalar_op,
    input  logic                      insn_req,
    output logic                      insn_ack,
    // memory port
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [VLEN-1:0]           mem_wdata,
    input  logic                      mem_ack,
    input  logic [VLEN-1:0]           mem_rdata
);
    localparam int RA_W = $clog2(NUM_VREG);

    logic [RA_W-1:0]     rd_addr_a;
    logic [RA_W-1:0]     rd_addr_b;
    logic [VLEN-1:0]     rd_data_a;
    logic [VLEN-1:0]     rd_data_b;
    logic                claim;
    logic [RA_W-1:0]     claim_addr;
    logic [NUM_VREG-1:0] busy;

    alu_issue_if #(.VLEN(VLEN), .NUM_VREG(NUM_VREG)) alu_bus ();
    mem_issue_if #(.VLEN(VLEN), .NUM_VREG(NUM_VREG), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) mem_bus ();
    vreg_wb_if   #(.VLEN(VLEN), .NUM_VREG(NUM_VREG)) alu_wb ();
    vreg_wb_if   #(.VLEN(VLEN), .NUM_VREG(NUM_VREG)) mem_wb ();

    insn_dispatch #(.VLEN(VLEN), .NUM_VREG(NUM_VREG), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_dispatch (
        .clk, .rst_n, .insn, .scalar_op, .insn_req, .insn_ack,
        .alu(alu_bus.src), .mem(mem_bus.src),
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .claim, .claim_addr, .busy
    );

    valu_pipe #(.VLEN(VLEN), .NUM_VREG(NUM_VREG)) u_valu (
        .clk, .rst_n, .issue(alu_bus.sink), .wb(alu_wb.src)
    );

    vmem_unit #(.VLEN(VLEN), .NUM_VREG(NUM_VREG), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_vmem (
        .clk, .rst_n, .issue(mem_bus.sink), .wb(mem_wb.src),
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    vreg_file #(.VLEN(VLEN), .NUM_VREG(NUM_VREG)) u_vrf (
        .clk, .rst_n, .alu_wb(alu_wb.sink), .mem_wb(mem_wb.sink),
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .claim, .claim_addr, .busy
    );

endmodule

/* hw/rvv_elem_pkg.sv */
package rvv_elem_pkg;

    // width of the sew code
    localparam int sew_w = 2;

    // sew codes as held in the core
    localparam logic [sew_w-1:0] sew_e8  = 2'd0;
    localparam logic [sew_w-1:0] sew_e16 = 2'd1;
    localparam logic [sew_w-1:0] sew_e32 = 2'd2;
    localparam logic [sew_w-1:0] sew_e64 = 2'd3;

    // lane width per sew
    localparam int lane_bits_e8  = 8;
    localparam int lane_bits_e16 = 16;
    localparam int lane_bits_e32 = 32;
    localparam int lane_bits_e64 = 64;

endpackage

/* hw/rvv_isa_pkg.sv */
package rvv_isa_pkg;

    // major opcodes
    localparam logic [6:0] opc_load  = 7'h07;
    localparam logic [6:0] opc_store = 7'h27;
    localparam logic [6:0] opc_op_v  = 7'h57;

    // funct3 categories under op_v
    localparam logic [2:0] f3_ivv = 3'd0;
    localparam logic [2:0] f3_ivi = 3'd3;
    localparam logic [2:0] f3_cfg = 3'd7;

    // integer funct6 codes kept in this slice
    localparam logic [5:0] f6_add = 6'h00;
    localparam logic [5:0] f6_sub = 6'h02;
    localparam logic [5:0] f6_and = 6'h09;
    localparam logic [5:0] f6_or  = 6'h0a;
    localparam logic [5:0] f6_xor = 6'h0b;

    // vsetvli vsew field, bits 25:23
    localparam int vsew_lsb = 23;

    // op_v layout, vs1 holds simm5 for .vi
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } arith_fmt_t;

    // load/store layout, vd is vs3 on a store
    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] lumop;
        logic [4:0] rs1;
        logic [2:0] width;
        logic [4:0] vd;
        logic [6:0] opcode;
    } mem_fmt_t;

    typedef union packed {
        arith_fmt_t  arith;
        mem_fmt_t    mem;
        logic [31:0] bits;
    } insn_t;

endpackage

/* hw/valu_pipe.sv */
`timescale 1ns/1ns

module valu_pipe #(
    parameter int VLEN     = 64,
    parameter int NUM_VREG = 32
) (
    input logic       clk,
    input logic       rst_n,
    alu_issue_if.sink issue,
    vreg_wb_if.src    wb
);
    localparam int RA_W  = $clog2(NUM_VREG);
    localparam int NBYTE = VLEN / 8;
    localparam int L8    = rvv_elem_pkg::lane_bits_e8;
    localparam int L16   = rvv_elem_pkg::lane_bits_e16;
    localparam int L32   = rvv_elem_pkg::lane_bits_e32;
    localparam int L64   = rvv_elem_pkg::lane_bits_e64;

    logic                           s1_valid;
    logic [5:0]                     s1_funct6;
    logic [rvv_elem_pkg::sew_w-1:0] s1_sew;
    logic [RA_W-1:0]                s1_vd;
    logic [VLEN-1:0]                s1_a;
    logic [VLEN-1:0]                s1_b;
    logic [VLEN-1:0]                imm_vec;
    logic [VLEN-1:0]                a_in;
    logic [VLEN-1:0]                sum;
    logic [8:0]                     byte_sum;
    logic                           carry;
    logic                           is_sub;
    int                             lane_bytes;

    // simm5 sign-extended to the element, copied to every lane
    always_comb begin
        case (issue.sew)
            rvv_elem_pkg::sew_e8:  imm_vec = {(VLEN / L8){{(L8 - 5){issue.imm[4]}}, issue.imm}};
            rvv_elem_pkg::sew_e16: imm_vec = {(VLEN / L16){{(L16 - 5){issue.imm[4]}}, issue.imm}};
            rvv_elem_pkg::sew_e32: imm_vec = {(VLEN / L32){{(L32 - 5){issue.imm[4]}}, issue.imm}};
            default:               imm_vec = {(VLEN / L64){{(L64 - 5){issue.imm[4]}}, issue.imm}};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= issue.valid;
    end

    // stage 1 operands
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            s1_funct6 <= issue.funct6;
            s1_sew    <= issue.sew;
            s1_vd     <= issue.vd;
            s1_a      <= issue.is_imm ? imm_vec : issue.opnd_a;
            s1_b      <= issue.opnd_b;
        end
    end

    // vsub is vs2 - vs1, done as b + ~a + 1
    assign is_sub     = s1_funct6 == rvv_isa_pkg::f6_sub;
    assign a_in       = is_sub ? ~s1_a : s1_a;
    assign lane_bytes = 1 << s1_sew;

    // byte ripple, carry restarts at every lane boundary
    always_comb begin
        carry    = is_sub;
        byte_sum = '0;
        for (int k = 0; k < NBYTE; k++) begin
            if ((k & (lane_bytes - 1)) == 0)
                carry = is_sub;
            byte_sum = {1'b0, s1_b[k*8 +: 8]} + {1'b0, a_in[k*8 +: 8]} + {8'd0, carry};
            sum[k*8 +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    // stage 2 result goes straight to the register file
    always_comb begin
        case (s1_funct6)
            rvv_isa_pkg::f6_and: wb.wdata = s1_a & s1_b;
            rvv_isa_pkg::f6_or:  wb.wdata = s1_a | s1_b;
            rvv_isa_pkg::f6_xor: wb.wdata = s1_a ^ s1_b;
            default:             wb.wdata = sum;
        endcase
    end

    assign wb.we    = s1_valid;
    assign wb.waddr = s1_vd;

endmodule

/* hw/vec_unit_if.sv */
`timescale 1ns/1ns

// dispatch to alu, single-cycle valid, no back-pressure
interface alu_issue_if #(
    parameter int VLEN     = 64,
    parameter int NUM_VREG = 32
);
    logic                           valid;
    logic [5:0]                     funct6;
    logic                           is_imm;
    logic [rvv_elem_pkg::sew_w-1:0] sew;
    logic [$clog2(NUM_VREG)-1:0]    vd;
    // a is vs1, b is vs2
    logic [VLEN-1:0]                opnd_a;
    logic [VLEN-1:0]                opnd_b;
    logic [4:0]                     imm;

    modport src  (output valid, funct6, is_imm, sew, vd, opnd_a, opnd_b, imm);
    modport sink (input  valid, funct6, is_imm, sew, vd, opnd_a, opnd_b, imm);
endinterface

// dispatch to memory unit, four-phase req/ack
interface mem_issue_if #(
    parameter int VLEN           = 64,
    parameter int NUM_VREG       = 32,
    parameter int MEM_ADDR_WIDTH = 32
);
    logic                        req;
    logic                        ack;
    logic                        is_store;
    logic [$clog2(NUM_VREG)-1:0] vd;
    logic [MEM_ADDR_WIDTH-1:0]   addr;
    logic [VLEN-1:0]             wdata;

    modport src  (output req, is_store, vd, addr, wdata, input  ack);
    modport sink (input  req, is_store, vd, addr, wdata, output ack);
endinterface

// one write stream into the register file
interface vreg_wb_if #(
    parameter int VLEN     = 64,
    parameter int NUM_VREG = 32
);
    logic                        we;
    logic [$clog2(NUM_VREG)-1:0] waddr;
    logic [VLEN-1:0]             wdata;

    modport src  (output we, waddr, wdata);
    modport sink (input  we, waddr, wdata);
endinterface

/* hw/vmem_unit.sv */
`timescale 1ns/1ns

module vmem_unit #(
    parameter int VLEN           = 64,
    parameter int NUM_VREG       = 32,
    parameter int MEM_ADDR_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    mem_issue_if.sink                 issue,
    vreg_wb_if.src                    wb,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [VLEN-1:0]           mem_wdata,
    input  logic                      mem_ack,
    input  logic [VLEN-1:0]           mem_rdata
);
    localparam logic [1:0] s_idle    = 2'd0;
    localparam logic [1:0] s_request = 2'd1;
    localparam logic [1:0] s_release = 2'd2;
    localparam logic [1:0] s_commit  = 2'd3;

    logic [1:0]                  state;
    logic [$clog2(NUM_VREG)-1:0] vd_q;
    logic [VLEN-1:0]             rdata_q;
    logic                        accept;
    logic                        mem_done;

    assign accept   = state == s_idle && issue.req && !issue.ack;
    assign mem_done = state == s_request && mem_req && mem_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= s_idle;
            mem_req   <= 1'b0;
            issue.ack <= 1'b0;
        end else begin
            case (state)
                s_idle: if (accept) begin
                    issue.ack <= 1'b1;
                    state     <= s_request;
                end
                // req only rises once the previous ack is gone
                s_request: if (!mem_req && !mem_ack) begin
                    mem_req <= 1'b1;
                end else if (mem_done) begin
                    mem_req <= 1'b0;
                    state   <= s_release;
                end
                // wait for both the memory and dispatch to let go
                s_release: if (!mem_ack && !issue.req) begin
                    state <= s_commit;
                end
                default: begin
                    issue.ack <= 1'b0;
                    state     <= s_idle;
                end
            endcase
        end
    end

    // transaction fields and load data
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_we    <= issue.is_store;
            mem_addr  <= issue.addr;
            mem_wdata <= issue.wdata;
            vd_q      <= issue.vd;
        end
        if (mem_done)
            rdata_q <= mem_rdata;
    end

    // single write pulse in commit, loads only
    assign wb.we    = state == s_commit && !mem_we;
    assign wb.waddr = vd_q;
    assign wb.wdata = rdata_q;

endmodule

/* hw/vreg_file.sv */
`timescale 1ns/1ns

module vreg_file #(
    parameter int VLEN     = 64,
    parameter int NUM_VREG = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    vreg_wb_if.sink                     alu_wb,
    vreg_wb_if.sink                     mem_wb,
    input  logic [$clog2(NUM_VREG)-1:0] rd_addr_a,
    input  logic [$clog2(NUM_VREG)-1:0] rd_addr_b,
    output logic [VLEN-1:0]             rd_data_a,
    output logic [VLEN-1:0]             rd_data_b,
    input  logic                        claim,
    input  logic [$clog2(NUM_VREG)-1:0] claim_addr,
    output logic [NUM_VREG-1:0]         busy
);
    logic [VLEN-1:0]     regs [NUM_VREG];
    logic [NUM_VREG-1:0] busy_set;
    logic [NUM_VREG-1:0] busy_clr;

    // async read ports
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // both streams commit together, never the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREG; i++)
                regs[i] <= '0;
        end else begin
            if (alu_wb.we)
                regs[alu_wb.waddr] <= alu_wb.wdata;
            if (mem_wb.we)
                regs[mem_wb.waddr] <= mem_wb.wdata;
        end
    end

    // scoreboard set on claim, cleared by the owning write
    always_comb begin
        busy_set = '0;
        busy_clr = '0;
        if (claim)
            busy_set[claim_addr] = 1'b1;
        if (alu_wb.we)
            busy_clr[alu_wb.waddr] = 1'b1;
        if (mem_wb.we)
            busy_clr[mem_wb.waddr] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            busy <= '0;
        else
            busy <= (busy & ~busy_clr) | busy_set;
    end

endmodule

/* list.f */
hw/rvv_isa_pkg.sv
hw/rvv_elem_pkg.sv
hw/vec_unit_if.sv
hw/insn_dispatch.sv
hw/valu_pipe.sv
hw/vmem_unit.sv
hw/vreg_file.sv
hw/rvv_core_top.sv
verification/clk_gen.sv
verification/rvv_core_tb.sv

/* verification/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* verification/rvv_core_tb.sv */
`timescale 1ns/1ns

module rvv_core_tb;
    localparam int VLEN           = 64;
    localparam int NUM_VREG       = 32;
    localparam int MEM_ADDR_WIDTH = 32;
    // kind, insn, scalar, data
    localparam int REC_W          = 4 + 32 + MEM_ADDR_WIDTH + VLEN;
    localparam int MAX_REC        = 64;

    logic                      clk;
    logic                      rst_n;
    logic [31:0]               insn;
    logic [MEM_ADDR_WIDTH-1:0] scalar_op;
    logic                      insn_req;
    logic                      insn_ack;
    logic                      mem_req;
    logic                      mem_we;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [VLEN-1:0]           mem_wdata;
    logic                      mem_ack;
    logic [VLEN-1:0]           mem_rdata;

    logic [REC_W-1:0]          recs [MAX_REC];
    logic [VLEN-1:0]           ref_regs [NUM_VREG];
    logic [1:0]                ref_sew;
    int                        pending [$];
    int                        num_rec;
    int                        cycles;
    int                        limit;
    logic                      ack_q;
    logic                      req_q;
    logic                      mreq_q;
    logic                      mack_q;

    clk_gen #(.PERIOD(8), .RST_CYCLES(5)) u_clk (.clk, .rst_n);

    rvv_core_top #(.VLEN(VLEN), .NUM_VREG(NUM_VREG), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) uut (
        .clk, .rst_n, .insn, .scalar_op, .insn_req, .insn_ack,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [VLEN-1:0] got,
                              input logic [VLEN-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [MEM_ADDR_WIDTH-1:0] got,
                              input logic [MEM_ADDR_WIDTH-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // element rule per lane as vs2 op vs1 with wrap inside the lane
    function automatic logic [VLEN-1:0] lane_rule(input logic [5:0] f6, input logic [1:0] sew,
                                                  input logic [VLEN-1:0] a,
                                                  input logic [VLEN-1:0] b);
        int              lw;
        logic [63:0]     mask;
        logic [63:0]     ea;
        logic [63:0]     eb;
        logic [63:0]     er;
        logic [VLEN-1:0] res;
        lw   = 8 << sew;
        mask = (lw == 64) ? '1 : ((64'd1 << lw) - 64'd1);
        res  = '0;
        for (int i = 0; i < VLEN / lw; i++) begin
            ea = 64'(a >> (i * lw)) & mask;
            eb = 64'(b >> (i * lw)) & mask;
            case (f6)
                rvv_isa_pkg::f6_add: er = eb + ea;
                rvv_isa_pkg::f6_sub: er = eb - ea;
                rvv_isa_pkg::f6_and: er = eb & ea;
                rvv_isa_pkg::f6_or:  er = eb | ea;
                default:             er = eb ^ ea;
            endcase
            res = res | (VLEN'(er & mask) << (i * lw));
        end
        return res;
    endfunction

    // simm5 widened to the element and copied to each lane
    function automatic logic [VLEN-1:0] splat_imm(input logic [4:0] imm, input logic [1:0] sew);
        int              lw;
        logic [63:0]     mask;
        logic [VLEN-1:0] res;
        lw   = 8 << sew;
        mask = (lw == 64) ? '1 : ((64'd1 << lw) - 64'd1);
        res  = '0;
        for (int i = 0; i < VLEN / lw; i++)
            res = res | (VLEN'({{59{imm[4]}}, imm} & mask) << (i * lw));
        return res;
    endfunction

    // sequential model stepped as each instruction is issued
    task automatic model_step(input int idx);
        rvv_isa_pkg::insn_t w;
        logic [3:0]         kind;
        logic [VLEN-1:0]    data;
        logic               f6_known;
        w        = recs[idx][REC_W-5 -: 32];
        kind     = recs[idx][REC_W-1 -: 4];
        data     = recs[idx][VLEN-1:0];
        f6_known = w.arith.funct6 inside {rvv_isa_pkg::f6_add, rvv_isa_pkg::f6_sub,
                   rvv_isa_pkg::f6_and, rvv_isa_pkg::f6_or, rvv_isa_pkg::f6_xor};
        if (kind == 4'd1) begin
            ref_regs[w.mem.vd] = data;
        end else if (kind == 4'd2) begin
            if (ref_regs[w.mem.vd] !== data)
                fail_now($sformatf("Record %0d expects store data the model does not hold.", idx));
        end else if (w.arith.opcode == rvv_isa_pkg::opc_op_v) begin
            if (w.arith.funct3 == rvv_isa_pkg::f3_cfg && !w.bits[31] && !w.bits[25])
                ref_sew = w.bits[24:23];
            else if (f6_known && w.arith.funct3 == rvv_isa_pkg::f3_ivv)
                ref_regs[w.arith.vd] = lane_rule(w.arith.funct6, ref_sew,
                                                 ref_regs[w.arith.vs1], ref_regs[w.arith.vs2]);
            else if (f6_known && w.arith.funct3 == rvv_isa_pkg::f3_ivi)
                ref_regs[w.arith.vd] = lane_rule(w.arith.funct6, ref_sew,
                                                 splat_imm(w.arith.vs1, ref_sew),
                                                 ref_regs[w.arith.vs2]);
        end
    endtask

    // handshake monitor and cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            fail_now("The run went past its cycle limit without finishing.");
        if (insn_ack && !ack_q && !req_q)
            fail_now("insn_ack rose while insn_req was low.");
        if (!insn_ack && ack_q && req_q)
            fail_now("insn_ack fell while insn_req was still high.");
        if (!mem_req && mreq_q && !mack_q)
            fail_now("mem_req fell before mem_ack was given.");
        if (mem_req && !mreq_q && mack_q)
            fail_now("mem_req rose again while mem_ack was still high.");
        ack_q  = insn_ack;
        req_q  = insn_req;
        mreq_q = mem_req;
        mack_q = mem_ack;
    end

    // memory model with random ack delay
    initial begin
        int         idx;
        int         delay;
        logic [3:0] kind;
        void'($urandom(30479));
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !mem_ack) begin
                if (pending.size() == 0)
                    fail_now("The core made a memory request with no load or store pending.");
                idx  = pending.pop_front();
                kind = recs[idx][REC_W-1 -: 4];
                check_addr("mem_addr", mem_addr, recs[idx][VLEN +: MEM_ADDR_WIDTH]);
                if (kind == 4'd2) begin
                    if (!mem_we)
                        fail_now("A store reached memory as a read.");
                    check_word("mem_wdata", mem_wdata, recs[idx][VLEN-1:0]);
                end else if (mem_we) begin
                    fail_now("A load reached memory as a write.");
                end
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_rdata = recs[idx][VLEN-1:0];
                mem_ack   = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        logic [3:0] kind;
        insn      = '0;
        scalar_op = '0;
        insn_req  = 1'b0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        ack_q     = 1'b0;
        req_q     = 1'b0;
        mreq_q    = 1'b0;
        mack_q    = 1'b0;
        cycles    = 0;
        ref_sew   = rvv_elem_pkg::sew_e8;
        for (int i = 0; i < NUM_VREG; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < MAX_REC; i++)
            recs[i] = '1;
        $readmemh("verification/rvv_vectors.txt", recs);
        num_rec = 0;
        while (num_rec < MAX_REC && recs[num_rec][REC_W-1 -: 4] != 4'hf)
            num_rec++;
        limit = num_rec * 40 + 100;
        @(posedge rst_n);
        for (int r = 0; r < num_rec; r++) begin
            kind = recs[r][REC_W-1 -: 4];
            model_step(r);
            @(posedge clk);
            #1;
            insn      = recs[r][REC_W-5 -: 32];
            scalar_op = recs[r][VLEN +: MEM_ADDR_WIDTH];
            insn_req  = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (!insn_ack);
            if (kind == 4'd1 || kind == 4'd2)
                pending.push_back(r);
            insn_req = 1'b0;
            do begin
                @(posedge clk);
                #1;
            end while (insn_ack);
        end
        // drain the memory unit
        while (pending.size() != 0 || mem_req || mem_ack) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verification/rvv_vectors.txt */
// kind_insn_scalar_data, kind 0 exec, 1 load (memory returns data), 2 store (expected wdata)
// store records also give the value the register must hold at that point
2_020501a7_00000100_0000000000000000
1_02050087_00000200_80ff7f01fffe0003
1_02050107_00000208_01ff80017ffe0102
2_020500a7_00000300_80ff7f01fffe0003
// e8 add
0_022081d7_00000000_0000000000000000
2_020501a7_00000308_81feff027efc0105
// e16 sub
0_00807057_00000000_0000000000000000
0_0a208257_00000000_0000000000000000
2_02050227_00000310_81000100800000ff
// e32 logic ops and add
0_01007057_00000000_0000000000000000
0_262082d7_00000000_0000000000000000
0_2a208357_00000000_0000000000000000
0_2e2083d7_00000000_0000000000000000
0_02208457_00000000_0000000000000000
// e64 sub, then e16 add.vi with -3
0_01807057_00000000_0000000000000000
0_0a2084d7_00000000_0000000000000000
0_00807057_00000000_0000000000000000
0_021eb557_00000000_0000000000000000
2_020502a7_00000318_00ff00017ffe0002
2_02050327_00000320_81ffff01fffe0103
2_020503a7_00000328_8100ff0080000101
2_02050427_00000330_82feff027ffc0105
2_020504a7_00000338_810000ff800000ff
2_02050527_00000340_80fc7efefffb0000
// dependent chain at e16
1_02050587_00000400_7fff00018000ffff
0_02b58657_00000000_0000000000000000
0_02c58657_00000000_0000000000000000
2_02050627_00000410_7ffd00038000fffd
// not a vector instruction, no effect
0_00000013_00000000_0000000000000000
